// ==== project.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/regfile.sv
hw/stage_if.sv
hw/stage_id.sv
hw/stage_ex.sv
hw/stage_mem.sv
hw/pipeline.sv
tb/pipeline_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pipeline_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/pipeline_tb.sv ====
// testbench for the five-stage pipeline
// 64-bit line memory model, program builder with its own RV32I reference
// expected-commit table checked in a loop, two programs split by a reset
`timescale 1ns/1ns
`default_nettype none

module pipeline_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam logic [31:0] reset_addr = 32'h0000_0040;   // first fetch
    localparam logic [31:0] data_addr  = 32'h0000_0104;   // sw/lw target in the upper half of a line
    localparam int          lines      = 128;             // 1 KiB of memory
    localparam int          max_wait   = 20;              // cycles allowed per commit

    typedef struct packed {
        logic            wr_en;
        logic [4:0]      wr_idx;
        logic [31:0]     wr_data;
        logic [31:0]     npc;
        exception_code_t status;
    } commit_t;

    logic            clock;
    logic            reset;
    logic [63:0]     mem2proc_data;
    bus_command_t    proc2mem_command;
    logic [31:0]     proc2mem_addr;
    logic [63:0]     proc2mem_data;
    mem_size_t       proc2mem_size;
    logic            completed;
    exception_code_t error_status;
    logic            commit_wr_en;
    logic [4:0]      commit_wr_idx;
    logic [31:0]     commit_wr_data;
    logic [31:0]     commit_npc;

    logic [63:0] image [lines];                // program image built while in reset
    logic [63:0] mem   [lines];                // memory the DUT sees
    logic [31:0] xreg  [32];                   // register model
    logic [31:0] data_model [logic [31:0]];    // stored words by address
    logic [31:0] build_pc;                     // next free program slot
    commit_t     exp_rows  [$];
    string       exp_names [$];

    pipeline #(.reset_pc(reset_addr)) UUT (
        .clock            (clock),
        .reset            (reset),
        .mem2proc_data    (mem2proc_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data),
        .proc2mem_size    (proc2mem_size),
        .completed        (completed),
        .error_status     (error_status),
        .commit_wr_en     (commit_wr_en),
        .commit_wr_idx    (commit_wr_idx),
        .commit_wr_data   (commit_wr_data),
        .commit_npc       (commit_npc)
    );

    always #4 clock = ~clock;   // 8 ns period

    ////////////////////////////////////////////////////////////
    // zero-latency memory model
    ////////////////////////////////////////////////////////////

    // image shows through while reset holds
    assign mem2proc_data = reset ? image[proc2mem_addr[9:3]] : mem[proc2mem_addr[9:3]];

    always @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < lines; k++)
                mem[k] <= image[k];   // reload on every reset edge
        end else if (proc2mem_command == bus_store) begin
            check_value("sw_port", "mem size", 32'(mem_word), 32'(proc2mem_size));
            if (proc2mem_addr[2])
                mem[proc2mem_addr[9:3]][63:32] <= proc2mem_data[31:0];
            else
                mem[proc2mem_addr[9:3]][31:0] <= proc2mem_data[31:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // failure reporting and field checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else abort_run($sformatf("error %s: %s expected %h actual %h",
                                 name, field, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // instruction encoders for the RV32I formats
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] encode_i(input logic [6:0] opcode, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_b(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    ////////////////////////////////////////////////////////////
    // program builder adding a word and its expected commit per call
    ////////////////////////////////////////////////////////////

    task automatic fill_image;
        int k;
        // low bits 00 never form a legal opcode
        for (k = 0; k < lines; k++)
            image[k] = {16'ha5a5, 16'(k * 8 + 4), 16'h5a5a, 16'(k * 8)};
        build_pc = reset_addr;
        exp_rows.delete();
        exp_names.delete();
    endtask

    task automatic place_word(input logic [31:0] word);
        if (build_pc[2])
            image[build_pc[9:3]][63:32] = word;
        else
            image[build_pc[9:3]][31:0] = word;
        build_pc = build_pc + 32'd4;
    endtask

    task automatic expect_commit(input string name, input logic [4:0] rd,
                                 input logic [31:0] data, input exception_code_t status);
        commit_t row;
        row.wr_en   = (rd != 5'd0);
        row.wr_idx  = rd;
        row.wr_data = data;
        row.npc     = build_pc;       // slot after the one just placed
        row.status  = status;
        exp_rows.push_back(row);
        exp_names.push_back(name);
        if (rd != 5'd0)
            xreg[rd] = data;
    endtask

    task automatic add_imm(input string name, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
        place_word(encode_i(7'b0010011, 3'b000, rd, rs1, imm));
        expect_commit(name, rd, xreg[rs1] + sext12(imm), no_error);
    endtask

    task automatic reg_op(input string name, input alu_func_t func,
                          input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] result;
        f7     = 7'h00;
        f3     = 3'd0;
        result = xreg[rs1] + xreg[rs2];
        case (func)
            alu_sub: begin
                f7     = 7'h20;
                result = xreg[rs1] - xreg[rs2];
            end
            alu_and: begin
                f3     = 3'd7;
                result = xreg[rs1] & xreg[rs2];
            end
            alu_or: begin
                f3     = 3'd6;
                result = xreg[rs1] | xreg[rs2];
            end
            default: ;
        endcase
        place_word(encode_r(f7, f3, rd, rs1, rs2));
        expect_commit(name, rd, result, no_error);
    endtask

    task automatic store_word(input string name, input logic [4:0] rs2, input logic [4:0] rs1,
                              input logic [11:0] imm);
        place_word(encode_s(rs1, rs2, imm));
        data_model[xreg[rs1] + sext12(imm)] = xreg[rs2];
        expect_commit(name, 5'd0, 32'd0, no_error);
    endtask

    task automatic load_word(input string name, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
        place_word(encode_i(7'b0000011, 3'b010, rd, rs1, imm));
        expect_commit(name, rd, data_model[xreg[rs1] + sext12(imm)], no_error);
    endtask

    // beq over skip_n slots whose writes to x10 must never commit
    task automatic branch_eq(input string name, input logic [4:0] rs1, input logic [4:0] rs2,
                             input int skip_n);
        int   k;
        logic taken;
        taken = (xreg[rs1] == xreg[rs2]);
        place_word(encode_b(rs1, rs2, 13'(4 * (skip_n + 1))));
        expect_commit(name, 5'd0, 32'd0, no_error);
        if (taken) begin
            for (k = 0; k < skip_n; k++)
                place_word(encode_i(7'b0010011, 3'b000, 5'd10, 5'd0, 12'h7ff));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reset and the commit check loop
    ////////////////////////////////////////////////////////////

    task automatic check_reset_state;
        check_value("reset_hold", "completed", 32'd0, 32'(completed));
        check_value("reset_hold", "commit_wr_en", 32'd0, 32'(commit_wr_en));
        check_value("reset_hold", "fetch addr", reset_addr, proc2mem_addr);
        check_value("reset_hold", "mem command", 32'(bus_load), 32'(proc2mem_command));
        check_value("reset_hold", "mem size", 32'(mem_double), 32'(proc2mem_size));
    endtask

    // three reset edges and release 1 ns after the last
    task automatic apply_reset;
        int k;
        reset = 1'b1;
        for (k = 0; k < 3; k++) begin
            @(posedge clock);
            if (k < 2) begin
                @(negedge clock);
                check_reset_state();
            end
        end
        #1 reset = 1'b0;
    endtask

    task automatic run_commits;
        int      i;
        int      n;
        commit_t row;
        for (i = 0; i < exp_rows.size(); i++) begin
            n = 0;
            do begin
                @(negedge clock);   // outputs settled mid-cycle
                n++;
            end while (completed !== 1'b1 && n < max_wait);
            assert (completed === 1'b1)
            else abort_run($sformatf("timeout: %s did not commit within %0d cycles",
                                     exp_names[i], max_wait));
            row = exp_rows[i];
            check_value(exp_names[i], "commit_wr_en", 32'(row.wr_en), 32'(commit_wr_en));
            if (row.wr_en) begin
                check_value(exp_names[i], "commit_wr_idx", 32'(row.wr_idx), 32'(commit_wr_idx));
                check_value(exp_names[i], "commit_wr_data", row.wr_data, commit_wr_data);
            end
            check_value(exp_names[i], "commit_npc", row.npc, commit_npc);
            check_value(exp_names[i], "error_status", 32'(row.status), 32'(error_status));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int k;
        clock = 1'b0;
        reset = 1'b1;
        void'($urandom(32'h128e_f4dc));
        for (k = 0; k < 32; k++)
            xreg[k] = 32'd0;

        // program 1 with alu ops, x0, sw/lw, both beq outcomes and wfi
        fill_image();
        add_imm("addi_x1_random", 5'd1, 5'd0, 12'($urandom()));
        add_imm("addi_x2_random", 5'd2, 5'd0, 12'($urandom()));
        reg_op("add_x3", alu_add, 5'd3, 5'd1, 5'd2);
        reg_op("sub_x4", alu_sub, 5'd4, 5'd1, 5'd2);
        reg_op("and_x5", alu_and, 5'd5, 5'd1, 5'd2);
        reg_op("or_x6", alu_or, 5'd6, 5'd1, 5'd2);
        add_imm("addi_to_x0", 5'd0, 5'd1, 12'd5);       // no write
        reg_op("add_x7_reads_x0", alu_add, 5'd7, 5'd0, 5'd1);
        add_imm("addi_x8_base", 5'd8, 5'd0, 12'h100);
        store_word("sw_x3", 5'd3, 5'd8, 12'd4);
        load_word("lw_x9", 5'd9, 5'd8, 12'd4);
        branch_eq("beq_taken", 5'd1, 5'd7, 2);          // x7 equals x1
        add_imm("addi_at_target", 5'd11, 5'd9, 12'd1);
        add_imm("addi_x12_one", 5'd12, 5'd0, 12'd1);
        branch_eq("beq_not_taken", 5'd0, 5'd12, 2);
        add_imm("addi_fall_through", 5'd13, 5'd0, 12'd7);
        place_word(32'h1050_0073);                      // wfi
        expect_commit("wfi_halt", 5'd0, 32'd0, halted_on_wfi);

        apply_reset();
        run_commits();
        check_value("sw_lw_memory", "mem word", data_model[data_addr],
                    mem[data_addr[9:3]][63:32]);

        // program 2 after a fresh reset ends in an all-zero word
        @(posedge clock);
        #1;
        fill_image();
        add_imm("addi_x14_random", 5'd14, 5'd0, 12'($urandom()));
        reg_op("add_x15", alu_add, 5'd15, 5'd14, 5'd14);
        reg_op("sub_x16", alu_sub, 5'd16, 5'd15, 5'd14);
        place_word(32'h0000_0000);
        expect_commit("zero_word_illegal", 5'd0, 32'd0, illegal_inst);

        apply_reset();
        run_commits();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/pipeline.sv ====
// five-stage pipeline top, one instruction in flight
// stage registers, fetch valid loop, memory port arbitration, commit outputs
`timescale 1ns/1ns
`default_nettype none

module pipeline import isa_pkg::*, pipe_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic [63:0] mem2proc_data,
    output bus_command_t     proc2mem_command,
    output logic [xlen-1:0]  proc2mem_addr,
    output logic [63:0]      proc2mem_data,
    output mem_size_t        proc2mem_size,
    output logic             completed,
    output exception_code_t  error_status,
    output logic             commit_wr_en,
    output logic [4:0]       commit_wr_idx,
    output logic [xlen-1:0]  commit_wr_data,
    output logic [xlen-1:0]  commit_npc
);

    if_id_packet_t  if_packet, if_id_reg;
    id_ex_packet_t  id_packet, id_ex_reg;
    ex_mem_packet_t ex_packet, ex_mem_reg;
    mem_wb_packet_t mem_packet, mem_wb_reg;

    logic [xlen-1:0] proc2imem_addr;
    bus_command_t    proc2dmem_command;
    logic [xlen-1:0] proc2dmem_addr;
    mem_size_t       proc2dmem_size;
    logic [xlen-1:0] proc2dmem_data;

    logic            next_if_valid;
    logic            wb_regfile_en;
    logic [4:0]      wb_regfile_idx;
    logic [xlen-1:0] wb_regfile_data;

    ////////////////////////////////////////////////////////////
    // memory port, mem stage wins over fetch
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (proc2dmem_command != bus_none) begin
            proc2mem_command = proc2dmem_command;
            proc2mem_addr    = proc2dmem_addr;
            proc2mem_size    = proc2dmem_size;
        end else begin
            proc2mem_command = bus_load;        // instruction fetch
            proc2mem_addr    = proc2imem_addr;
            proc2mem_size    = mem_double;      // full 64-bit line
        end
        proc2mem_data = {32'b0, proc2dmem_data};
    end

    // fetch re-armed when the previous instruction reaches writeback
    always_ff @(posedge clock) begin
        if (reset)
            next_if_valid <= 1'b1;
        else
            next_if_valid <= mem_wb_reg.valid;
    end

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    stage_if #(.reset_pc(reset_pc)) stage_if_0 (
        .clock            (clock),
        .reset            (reset),
        .if_valid         (next_if_valid),
        .take_branch      (ex_mem_reg.take_branch),
        .branch_target_pc (ex_mem_reg.alu_result),
        .imem_data        (mem2proc_data),
        .if_packet        (if_packet),
        .proc2imem_addr   (proc2imem_addr)
    );

    stage_id stage_id_0 (
        .clock           (clock),
        .reset           (reset),
        .if_id_reg       (if_id_reg),
        .wb_regfile_en   (wb_regfile_en),
        .wb_regfile_idx  (wb_regfile_idx),
        .wb_regfile_data (wb_regfile_data),
        .id_packet       (id_packet)
    );

    stage_ex stage_ex_0 (
        .id_ex_reg (id_ex_reg),
        .ex_packet (ex_packet)
    );

    stage_mem stage_mem_0 (
        .ex_mem_reg        (ex_mem_reg),
        .dmem_data         (mem2proc_data),
        .mem_packet        (mem_packet),
        .proc2dmem_command (proc2dmem_command),
        .proc2dmem_addr    (proc2dmem_addr),
        .proc2dmem_size    (proc2dmem_size),
        .proc2dmem_data    (proc2dmem_data)
    );

    ////////////////////////////////////////////////////////////
    // stage registers, always enabled
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            if_id_reg      <= '{inst: nop_inst, pc: '0, npc: '0, valid: 1'b0};
            id_ex_reg      <= '0;
            id_ex_reg.inst <= nop_inst;   // nop is not all zero
            ex_mem_reg     <= '0;
            mem_wb_reg     <= '0;
        end else begin
            if_id_reg  <= if_packet;
            id_ex_reg  <= id_packet;
            ex_mem_reg <= ex_packet;
            mem_wb_reg <= mem_packet;
        end
    end

    ////////////////////////////////////////////////////////////
    // writeback and commit
    ////////////////////////////////////////////////////////////

    assign wb_regfile_en   = mem_wb_reg.valid && (mem_wb_reg.dest_reg_idx != 5'd0);
    assign wb_regfile_idx  = mem_wb_reg.dest_reg_idx;
    assign wb_regfile_data = mem_wb_reg.result;

    assign completed      = mem_wb_reg.valid;   // one pulse per instruction
    assign commit_wr_en   = wb_regfile_en;
    assign commit_wr_idx  = wb_regfile_idx;
    assign commit_wr_data = wb_regfile_data;
    assign commit_npc     = mem_wb_reg.npc;

    // illegal reported ahead of halt
    assign error_status = mem_wb_reg.illegal ? illegal_inst :
                          mem_wb_reg.halt    ? halted_on_wfi : no_error;

endmodule

`default_nettype wire

// ==== hw/stage_mem.sv ====
// memory stage
// data port command generation, load word capture
`timescale 1ns/1ns
`default_nettype none

module stage_mem import isa_pkg::*, pipe_pkg::*; (
    input  wire ex_mem_packet_t  ex_mem_reg,
    input  wire logic [63:0]     dmem_data,
    output mem_wb_packet_t       mem_packet,
    output bus_command_t         proc2dmem_command,
    output logic [xlen-1:0]      proc2dmem_addr,
    output mem_size_t            proc2dmem_size,
    output logic [xlen-1:0]      proc2dmem_data
);

    logic [xlen-1:0] load_word;

    always_comb begin
        if (ex_mem_reg.valid && ex_mem_reg.rd_mem)
            proc2dmem_command = bus_load;
        else if (ex_mem_reg.valid && ex_mem_reg.wr_mem)
            proc2dmem_command = bus_store;
        else
            proc2dmem_command = bus_none;   // port goes to fetch
    end

    assign proc2dmem_addr = ex_mem_reg.alu_result;
    assign proc2dmem_size = mem_word;      // word accesses only
    assign proc2dmem_data = ex_mem_reg.rs2_value;

    // addr bit 2 picks the word within the line
    assign load_word = ex_mem_reg.alu_result[2] ? dmem_data[63:32] : dmem_data[31:0];

    always_comb begin
        mem_packet.result       = ex_mem_reg.rd_mem ? load_word : ex_mem_reg.alu_result;
        mem_packet.npc          = ex_mem_reg.npc;
        mem_packet.dest_reg_idx = ex_mem_reg.dest_reg_idx;
        mem_packet.halt         = ex_mem_reg.halt;
        mem_packet.illegal      = ex_mem_reg.illegal;
        mem_packet.valid        = ex_mem_reg.valid;
    end

endmodule

`default_nettype wire

// ==== hw/stage_ex.sv ====
// execute stage
// operand B select, ALU, beq compare and target
`timescale 1ns/1ns
`default_nettype none

module stage_ex import isa_pkg::*, pipe_pkg::*; (
    input  wire id_ex_packet_t id_ex_reg,
    output ex_mem_packet_t     ex_packet
);

    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_out;
    alu_func_t       func;

    assign opb  = id_ex_reg.opb_is_imm ? id_ex_reg.imm : id_ex_reg.rs2_value;
    // address generation always adds
    assign func = (id_ex_reg.rd_mem || id_ex_reg.wr_mem) ? alu_add : id_ex_reg.alu_func;

    always_comb begin
        case (func)
            alu_sub: alu_out = id_ex_reg.rs1_value - opb;
            alu_and: alu_out = id_ex_reg.rs1_value & opb;
            alu_or:  alu_out = id_ex_reg.rs1_value | opb;
            default: alu_out = id_ex_reg.rs1_value + opb;
        endcase
    end

    always_comb begin
        ex_packet.npc          = id_ex_reg.npc;
        ex_packet.rs2_value    = id_ex_reg.rs2_value;
        ex_packet.rd_mem       = id_ex_reg.rd_mem;
        ex_packet.wr_mem       = id_ex_reg.wr_mem;
        ex_packet.dest_reg_idx = id_ex_reg.dest_reg_idx;
        ex_packet.halt         = id_ex_reg.halt;
        ex_packet.illegal      = id_ex_reg.illegal;
        ex_packet.valid        = id_ex_reg.valid;

        // branches carry the target in alu_result
        if (id_ex_reg.cond_br)
            ex_packet.alu_result = id_ex_reg.pc + id_ex_reg.imm;
        else
            ex_packet.alu_result = alu_out;

        ex_packet.take_branch = id_ex_reg.valid && id_ex_reg.cond_br &&
                                (id_ex_reg.rs1_value == id_ex_reg.rs2_value);
    end

endmodule

`default_nettype wire

// ==== hw/stage_id.sv ====
// decode stage
// format decode through inst_t, immediates, control bits, register read
`timescale 1ns/1ns
`default_nettype none

module stage_id import isa_pkg::*, pipe_pkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire if_id_packet_t   if_id_reg,
    input  wire logic            wb_regfile_en,
    input  wire logic [4:0]      wb_regfile_idx,
    input  wire logic [xlen-1:0] wb_regfile_data,
    output id_ex_packet_t        id_packet
);

    inst_t           inst;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic            bad;   // encoding not in the subset

    assign inst = if_id_reg.inst;

    // sign-extended immediates per format
    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};

    regfile regfile_0 (
        .clock    (clock),
        .reset    (reset),
        .rd1_idx  (inst.r.rs1),    // rs1 and rs2 sit in the same bits
        .rd2_idx  (inst.r.rs2),    // in every format
        .wr_en    (wb_regfile_en),
        .wr_idx   (wb_regfile_idx),
        .wr_data  (wb_regfile_data),
        .rd1_data (id_packet.rs1_value),
        .rd2_data (id_packet.rs2_value)
    );

    ////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        id_packet.inst         = inst;
        id_packet.pc           = if_id_reg.pc;
        id_packet.npc          = if_id_reg.npc;
        id_packet.valid        = if_id_reg.valid;
        id_packet.imm          = imm_i;
        id_packet.opb_is_imm   = 1'b0;
        id_packet.alu_func     = alu_add;
        id_packet.rd_mem       = 1'b0;
        id_packet.wr_mem       = 1'b0;
        id_packet.cond_br      = 1'b0;
        id_packet.dest_reg_idx = 5'd0;
        id_packet.halt         = 1'b0;
        bad                    = 1'b0;

        case (inst.r.opcode)
            op_reg: begin
                id_packet.dest_reg_idx = inst.r.rd;
                case ({inst.r.funct7, inst.r.funct3})
                    10'b0000000_000: id_packet.alu_func = alu_add;
                    10'b0100000_000: id_packet.alu_func = alu_sub;
                    10'b0000000_111: id_packet.alu_func = alu_and;
                    10'b0000000_110: id_packet.alu_func = alu_or;
                    default:         bad = 1'b1;
                endcase
            end
            op_imm: begin   // addi only
                id_packet.opb_is_imm   = 1'b1;
                id_packet.dest_reg_idx = inst.i.rd;
                bad = (inst.i.funct3 != 3'b000);
            end
            op_load: begin  // lw only
                id_packet.opb_is_imm   = 1'b1;
                id_packet.rd_mem       = 1'b1;
                id_packet.dest_reg_idx = inst.i.rd;
                bad = (inst.i.funct3 != 3'b010);
            end
            op_store: begin // sw only
                id_packet.imm        = imm_s;
                id_packet.opb_is_imm = 1'b1;
                id_packet.wr_mem     = 1'b1;
                bad = (inst.s.funct3 != 3'b010);
            end
            op_branch: begin // beq only
                id_packet.imm     = imm_b;
                id_packet.cond_br = 1'b1;
                bad = (inst.b.funct3 != 3'b000);
            end
            op_system: begin
                // wfi is 0x105 in the imm field, all other fields zero
                id_packet.halt = (inst.raw[31:7] == {12'h105, 13'd0});
                bad = !id_packet.halt;
            end
            default: bad = 1'b1;
        endcase

        // an illegal word touches nothing
        if (bad) begin
            id_packet.rd_mem       = 1'b0;
            id_packet.wr_mem       = 1'b0;
            id_packet.cond_br      = 1'b0;
            id_packet.dest_reg_idx = 5'd0;
        end
        id_packet.illegal = bad && if_id_reg.valid;
    end

endmodule

`default_nettype wire

// ==== hw/stage_if.sv ====
// fetch stage
// program counter, instruction word select from the 64-bit line
`timescale 1ns/1ns
`default_nettype none

module stage_if import isa_pkg::*, pipe_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            if_valid,          // fetch slot armed
    input  wire logic            take_branch,
    input  wire logic [xlen-1:0] branch_target_pc,
    input  wire logic [63:0]     imem_data,
    output if_id_packet_t        if_packet,
    output logic [xlen-1:0]      proc2imem_addr
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;

    assign pc_plus4       = pc + 32'd4;
    assign proc2imem_addr = pc;   // line fetch, bit 2 picks the half

    // redirect arrives from ex_mem while fetch is idle, so it also enables
    always_ff @(posedge clock) begin
        if (reset)
            pc <= reset_pc;
        else if (take_branch)
            pc <= branch_target_pc;
        else if (if_valid)
            pc <= pc_plus4;
    end

    always_comb begin
        if_packet.pc    = pc;
        if_packet.npc   = pc_plus4;
        if_packet.valid = if_valid;
        if (!if_valid)
            if_packet.inst = nop_inst;             // bubble
        else if (pc[2])
            if_packet.inst = imem_data[63:32];    // upper word of line
        else
            if_packet.inst = imem_data[31:0];
    end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
// 32x32 register file, two async reads, one sync write
// x0 reads zero, same-cycle write forwarded to reads
`timescale 1ns/1ns
`default_nettype none

module regfile import isa_pkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic [4:0]      rd1_idx,
    input  wire logic [4:0]      rd2_idx,
    input  wire logic            wr_en,
    input  wire logic [4:0]      wr_idx,
    input  wire logic [xlen-1:0] wr_data,
    output logic [xlen-1:0]      rd1_data,
    output logic [xlen-1:0]      rd2_data
);

    logic [xlen-1:0] regs [31:0];   // entry 0 never written

    function automatic logic [xlen-1:0] read_port(input logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        else if (wr_en && wr_idx == idx)
            return wr_data;         // bypass the write
        else
            return regs[idx];
    endfunction

    always_comb begin
        rd1_data = read_port(rd1_idx);
        rd2_data = read_port(rd2_idx);
    end

    always_ff @(posedge clock) begin
        if (!reset && wr_en && wr_idx != 5'd0)   // no writes while in reset
            regs[wr_idx] <= wr_data;
    end

endmodule

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
// pipeline packet types between stages
// memory bus command and access size
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // byte is a keyword, hence the prefix
    typedef enum logic [1:0] {
        mem_byte   = 2'h0,
        mem_half   = 2'h1,
        mem_word   = 2'h2,
        mem_double = 2'h3
    } mem_size_t;

    ////////////////////////////////////////////////////////////
    // stage packets
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        inst_t            inst;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  npc;     // pc + 4
        logic             valid;
    } if_id_packet_t;

    typedef struct packed {
        inst_t            inst;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  npc;
        logic [xlen-1:0]  rs1_value;
        logic [xlen-1:0]  rs2_value;
        logic [xlen-1:0]  imm;          // already sign extended
        logic             opb_is_imm;
        alu_func_t        alu_func;
        logic             rd_mem;
        logic             wr_mem;
        logic             cond_br;      // beq
        logic [4:0]       dest_reg_idx; // zero when nothing is written
        logic             halt;
        logic             illegal;
        logic             valid;
    } id_ex_packet_t;

    typedef struct packed {
        logic [xlen-1:0]  alu_result;   // also branch target and mem address
        logic [xlen-1:0]  npc;
        logic [xlen-1:0]  rs2_value;    // store data
        logic             take_branch;
        logic             rd_mem;
        logic             wr_mem;
        logic [4:0]       dest_reg_idx;
        logic             halt;
        logic             illegal;
        logic             valid;
    } ex_mem_packet_t;

    typedef struct packed {
        logic [xlen-1:0]  result;
        logic [xlen-1:0]  npc;
        logic [4:0]       dest_reg_idx;
        logic             halt;
        logic             illegal;
        logic             valid;
    } mem_wb_packet_t;

endpackage

`default_nettype wire

// ==== hw/isa_pkg.sv ====
// RV32I subset definitions
// instruction formats and their union, opcodes, ALU functions, exception codes
`default_nettype none

package isa_pkg;

    localparam int xlen = 32;   // data and address width

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_system = 7'b1110011   // only wfi decoded
    } opcode_t;

    ////////////////////////////////////////////////////////////
    // instruction formats, msb first
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;    // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;    // imm[4:0]
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    // one fetched word, viewed per format
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        logic [31:0] raw;
    } inst_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_func_t;

    typedef enum logic [1:0] {
        no_error,
        halted_on_wfi,
        illegal_inst
    } exception_code_t;

    localparam inst_t nop_inst = 32'h0000_0013;   // addi x0, x0, 0

endpackage

`default_nettype wire
